//--- hdl/oscope_pkg.sv
// oscope shared types
`default_nettype none

package oscope_pkg;

	// host link and sample widths
	typedef logic [7:0] byte_t;
	typedef logic [15:0] sample_t;

	// spi register access
	typedef logic [6:0] spi_addr_t;
	typedef logic [15:0] spi_data_t;

	// read flag, address, data; shifted out msb first
	typedef logic [23:0] spi_frame_t;

	// host command bytes
	typedef enum logic [7:0] {
		CMD_SPI_WRITE = 8'h01,
		CMD_SPI_READ  = 8'h02,
		CMD_ARM       = 8'h03,
		CMD_READ_BUF  = 8'h04
	} cmd_t;

	// response bytes
	localparam byte_t RESP_ACK = 8'hA5;
	localparam byte_t RESP_BAD = 8'hEE;

	// command decoder states
	typedef enum logic [3:0] {
		DEC_IDLE,
		DEC_ARGS,
		DEC_SPI_START,
		DEC_SPI_WAIT,
		DEC_ARM,
		DEC_CAP_WAIT,
		DEC_BUF_WAIT,
		DEC_BUF_LOAD,
		DEC_TX
	} dec_state_t;

endpackage

`default_nettype wire

//--- hdl/spi_chain_master.sv
// spi frame master
`default_nettype none
`timescale 1ns/1ps

module spi_chain_master #(
	parameter int SPI_CLK_DIV = 2
) (
	input wire lb_clk_i,
	input wire rst_i,
	input wire start_i,
	input wire oscope_pkg::spi_frame_t frame_i,
	output logic busy_o,
	output oscope_pkg::spi_data_t rdbk_o,
	output logic spi_sclk_o,
	output logic spi_mosi_o,
	input wire spi_miso_i,
	output logic spi_ssb_o
);
	import oscope_pkg::*;

	localparam int DIV_W = $clog2(SPI_CLK_DIV + 1);
	// two sclk edges per frame bit
	localparam int HALF_CNT = 2 * $bits(spi_frame_t);

	logic [DIV_W-1:0] div_cnt;
	logic [5:0] half_cnt;
	logic tick;
	logic frame_end;
	spi_frame_t tx_sr;
	spi_data_t rx_sr;

	assign tick = (div_cnt == DIV_W'(SPI_CLK_DIV - 1));
	assign frame_end = (half_cnt == 6'(HALF_CNT));
	assign spi_mosi_o = tx_sr[$bits(spi_frame_t)-1];
	assign rdbk_o = rx_sr;

	always_ff @(posedge lb_clk_i) begin
		if (rst_i) begin
			busy_o <= 1'b0;
			spi_ssb_o <= 1'b1;
			spi_sclk_o <= 1'b0;
			div_cnt <= '0;
			half_cnt <= '0;
			tx_sr <= '0;
		end else if (!busy_o) begin
			if (start_i) begin
				busy_o <= 1'b1;
				spi_ssb_o <= 1'b0;
				tx_sr <= frame_i;
				div_cnt <= '0;
				half_cnt <= '0;
			end
		end else if (frame_end) begin
			// one extra cycle with sclk low before ssb rises
			busy_o <= 1'b0;
			spi_ssb_o <= 1'b1;
		end else if (tick) begin
			div_cnt <= '0;
			spi_sclk_o <= ~spi_sclk_o;
			half_cnt <= half_cnt + 6'd1;
			// next bit on the falling edge
			if (spi_sclk_o)
				tx_sr <= tx_sr << 1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// miso sampled on the rising edge, last 16 bits kept
	always_ff @(posedge lb_clk_i) begin
		if (busy_o && !frame_end && tick && !spi_sclk_o)
			rx_sr <= {rx_sr[$bits(spi_data_t)-2:0], spi_miso_i};
	end

endmodule

`default_nettype wire

//--- hdl/sample_capture.sv
// adc sample capture buffer
`default_nettype none
`timescale 1ns/1ps

module sample_capture #(
	parameter int CAPTURE_DEPTH = 16
) (
	input wire lb_clk_i,
	input wire rst_i,
	input wire oscope_pkg::sample_t adc_data_i,
	input wire adc_valid_i,
	input wire arm_i,
	output logic done_o,
	input wire [$clog2(CAPTURE_DEPTH)-1:0] rd_addr_i,
	output oscope_pkg::sample_t rd_data_o
);
	import oscope_pkg::*;

	localparam int ADDR_W = $clog2(CAPTURE_DEPTH);

	sample_t mem [CAPTURE_DEPTH];
	sample_t adc_q;
	logic adc_valid_q;
	logic armed;
	logic [ADDR_W-1:0] wr_ptr;
	logic wr_en;

	assign wr_en = armed && adc_valid_q && !arm_i;

	// input stage, sample lands in memory one cycle later
	always_ff @(posedge lb_clk_i) begin
		adc_q <= adc_data_i;
	end

	always_ff @(posedge lb_clk_i) begin
		if (rst_i) begin
			adc_valid_q <= 1'b0;
			armed <= 1'b0;
			done_o <= 1'b0;
			wr_ptr <= '0;
		end else begin
			adc_valid_q <= adc_valid_i;
			if (arm_i) begin
				armed <= 1'b1;
				done_o <= 1'b0;
				wr_ptr <= '0;
			end else if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
				// buffer full, stop until the next arm
				if (wr_ptr == ADDR_W'(CAPTURE_DEPTH - 1)) begin
					armed <= 1'b0;
					done_o <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge lb_clk_i) begin
		if (wr_en)
			mem[wr_ptr] <= adc_q;
	end

	// registered read port
	always_ff @(posedge lb_clk_i) begin
		rd_data_o <= mem[rd_addr_i];
	end

endmodule

`default_nettype wire

//--- hdl/host_cmd_decoder.sv
// host command decoder
`default_nettype none
`timescale 1ns/1ps

module host_cmd_decoder #(
	parameter int CAPTURE_DEPTH = 16
) (
	input wire lb_clk_i,
	input wire rst_i,
	input wire oscope_pkg::byte_t host_rx_data_i,
	input wire host_rx_valid_i,
	output logic host_rx_ready_o,
	output oscope_pkg::byte_t host_tx_data_o,
	output logic host_tx_valid_o,
	input wire host_tx_ready_i,
	output logic spi_start_o,
	output oscope_pkg::spi_frame_t spi_frame_o,
	input wire spi_busy_i,
	input wire oscope_pkg::spi_data_t spi_rdbk_i,
	output logic cap_arm_o,
	input wire cap_done_i,
	output logic [$clog2(CAPTURE_DEPTH)-1:0] buf_addr_o,
	input wire oscope_pkg::sample_t buf_data_i
);
	import oscope_pkg::*;

	localparam int ADDR_W = $clog2(CAPTURE_DEPTH);

	dec_state_t state;
	byte_t cmd_q;
	byte_t tx_next_q;
	logic more_q;
	logic [1:0] arg_idx;
	logic [1:0] arg_last;
	logic rx_fire;

	assign host_rx_ready_o = (state == DEC_IDLE) || (state == DEC_ARGS);
	assign rx_fire = host_rx_valid_i && host_rx_ready_o;
	assign spi_start_o = (state == DEC_SPI_START);
	assign cap_arm_o = (state == DEC_ARM);
	assign arg_last = (cmd_q == CMD_SPI_READ) ? 2'd0 : 2'd2;

	always_ff @(posedge lb_clk_i) begin
		if (rst_i) begin
			state <= DEC_IDLE;
			host_tx_valid_o <= 1'b0;
			more_q <= 1'b0;
			arg_idx <= 2'd0;
			buf_addr_o <= '0;
		end else begin
			case (state)
			DEC_IDLE: begin
				if (rx_fire) begin
					cmd_q <= host_rx_data_i;
					arg_idx <= 2'd0;
					case (host_rx_data_i)
					CMD_SPI_WRITE, CMD_SPI_READ: begin
						spi_frame_o <= {(host_rx_data_i == CMD_SPI_READ), spi_addr_t'(0),
							spi_data_t'(0)};
						state <= DEC_ARGS;
					end
					CMD_ARM: state <= DEC_ARM;
					CMD_READ_BUF: begin
						buf_addr_o <= '0;
						state <= DEC_BUF_WAIT;
					end
					default: begin
						host_tx_data_o <= RESP_BAD;
						host_tx_valid_o <= 1'b1;
						more_q <= 1'b0;
						state <= DEC_TX;
					end
					endcase
				end
			end
			DEC_ARGS: begin
				if (rx_fire) begin
					// address first, then data high and low
					case (arg_idx)
					2'd0: spi_frame_o[22:16] <= host_rx_data_i[$bits(spi_addr_t)-1:0];
					2'd1: spi_frame_o[15:8] <= host_rx_data_i;
					default: spi_frame_o[7:0] <= host_rx_data_i;
					endcase
					arg_idx <= arg_idx + 2'd1;
					if (arg_idx == arg_last)
						state <= DEC_SPI_START;
				end
			end
			DEC_SPI_START: state <= DEC_SPI_WAIT;
			DEC_SPI_WAIT: begin
				if (!spi_busy_i) begin
					host_tx_valid_o <= 1'b1;
					state <= DEC_TX;
					if (cmd_q == CMD_SPI_READ) begin
						host_tx_data_o <= spi_rdbk_i[15:8];
						tx_next_q <= spi_rdbk_i[7:0];
						more_q <= 1'b1;
					end else begin
						host_tx_data_o <= RESP_ACK;
						more_q <= 1'b0;
					end
				end
			end
			DEC_ARM: state <= DEC_CAP_WAIT;
			DEC_CAP_WAIT: begin
				if (cap_done_i) begin
					host_tx_data_o <= RESP_ACK;
					host_tx_valid_o <= 1'b1;
					more_q <= 1'b0;
					state <= DEC_TX;
				end
			end
			// synchronous buffer read, data one cycle behind the address
			DEC_BUF_WAIT: state <= DEC_BUF_LOAD;
			DEC_BUF_LOAD: begin
				host_tx_data_o <= buf_data_i[15:8];
				tx_next_q <= buf_data_i[7:0];
				more_q <= 1'b1;
				host_tx_valid_o <= 1'b1;
				state <= DEC_TX;
			end
			DEC_TX: begin
				if (host_tx_ready_i) begin
					if (more_q) begin
						host_tx_data_o <= tx_next_q;
						more_q <= 1'b0;
					end else begin
						host_tx_valid_o <= 1'b0;
						if (cmd_q == CMD_READ_BUF &&
								buf_addr_o != ADDR_W'(CAPTURE_DEPTH - 1)) begin
							buf_addr_o <= buf_addr_o + 1'b1;
							state <= DEC_BUF_WAIT;
						end else begin
							state <= DEC_IDLE;
						end
					end
				end
			end
			default: state <= DEC_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/oscope_top.sv
// oscope top level
`default_nettype none
`timescale 1ns/1ps

module oscope_top #(
	parameter int SPI_CLK_DIV = 2,
	parameter int CAPTURE_DEPTH = 16
) (
	input wire lb_clk_i,
	input wire rst_i,
	input wire oscope_pkg::byte_t host_rx_data_i,
	input wire host_rx_valid_i,
	output logic host_rx_ready_o,
	output oscope_pkg::byte_t host_tx_data_o,
	output logic host_tx_valid_o,
	input wire host_tx_ready_i,
	input wire oscope_pkg::sample_t adc_data_i,
	input wire adc_valid_i,
	output logic spi_sclk_o,
	output logic spi_mosi_o,
	input wire spi_miso_i,
	output logic spi_ssb_o
);
	import oscope_pkg::*;

	localparam int ADDR_W = $clog2(CAPTURE_DEPTH);

	logic spi_start;
	spi_frame_t spi_frame;
	logic spi_busy;
	spi_data_t spi_rdbk;
	logic cap_arm;
	logic cap_done;
	logic [ADDR_W-1:0] buf_addr;
	sample_t buf_data;

	// command parsing and responses
	host_cmd_decoder #(.CAPTURE_DEPTH(CAPTURE_DEPTH)) host_cmd_decoder(
		.lb_clk_i(lb_clk_i),
		.rst_i(rst_i),
		.host_rx_data_i(host_rx_data_i),
		.host_rx_valid_i(host_rx_valid_i),
		.host_rx_ready_o(host_rx_ready_o),
		.host_tx_data_o(host_tx_data_o),
		.host_tx_valid_o(host_tx_valid_o),
		.host_tx_ready_i(host_tx_ready_i),
		.spi_start_o(spi_start),
		.spi_frame_o(spi_frame),
		.spi_busy_i(spi_busy),
		.spi_rdbk_i(spi_rdbk),
		.cap_arm_o(cap_arm),
		.cap_done_i(cap_done),
		.buf_addr_o(buf_addr),
		.buf_data_i(buf_data)
	);

	spi_chain_master #(.SPI_CLK_DIV(SPI_CLK_DIV)) spi_chain_master(
		.lb_clk_i(lb_clk_i),
		.rst_i(rst_i),
		.start_i(spi_start),
		.frame_i(spi_frame),
		.busy_o(spi_busy),
		.rdbk_o(spi_rdbk),
		.spi_sclk_o(spi_sclk_o),
		.spi_mosi_o(spi_mosi_o),
		.spi_miso_i(spi_miso_i),
		.spi_ssb_o(spi_ssb_o)
	);

	sample_capture #(.CAPTURE_DEPTH(CAPTURE_DEPTH)) sample_capture(
		.lb_clk_i(lb_clk_i),
		.rst_i(rst_i),
		.adc_data_i(adc_data_i),
		.adc_valid_i(adc_valid_i),
		.arm_i(cap_arm),
		.done_o(cap_done),
		.rd_addr_i(buf_addr),
		.rd_data_o(buf_data)
	);

endmodule

`default_nettype wire

//--- testbench/oscope_tb.sv
// oscope testbench
`default_nettype none
`timescale 1ns/1ps

module oscope_tb;
	import oscope_pkg::*;

	localparam int SPI_CLK_DIV = 2;
	localparam int CAPTURE_DEPTH = 16;
	localparam int N_CMDS = 18;
	localparam int WATCHDOG_CYCLES = N_CMDS * (48 * SPI_CLK_DIV + 4 * CAPTURE_DEPTH + 200);

	logic lb_clk_i;
	logic rst_i;
	byte_t host_rx_data_i;
	logic host_rx_valid_i;
	logic host_rx_ready_o;
	byte_t host_tx_data_o;
	logic host_tx_valid_o;
	logic host_tx_ready_i;
	sample_t adc_data_i;
	logic adc_valid_i;
	logic spi_sclk_o;
	logic spi_mosi_o;
	logic spi_miso_i;
	logic spi_ssb_o;

	integer seed = 32'h03f6_7003;

	// command in flight as set by the main sequence
	byte_t cur_cmd = 8'h00;
	spi_addr_t cur_addr = '0;
	spi_data_t cur_data = '0;
	int resp_start = 0;
	sample_t arm_ramp = '0;
	sample_t accept_ramp = '0;
	spi_data_t shadow_regs [128];

	// receive side state
	int byte_total = 0;
	byte_t hi_byte = '0;
	sample_t prev_sample = '0;
	sample_t last_cap_sample = '0;
	logic have_prev_cap = 1'b0;

	// spi slave model
	spi_data_t slave_regs [128];
	int frame_total = 0;

	oscope_top #(.SPI_CLK_DIV(SPI_CLK_DIV), .CAPTURE_DEPTH(CAPTURE_DEPTH)) DUT (.*);

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		if (got !== exp)
			fail_run($sformatf("Error: %s is %h, expected %h", name, got, exp));
	endtask

	task automatic check_sample(input string name, input sample_t got, input sample_t exp);
		if (got !== exp)
			fail_run($sformatf("Error: %s is %h, expected %h", name, got, exp));
	endtask

	task automatic check_spi_frame(input string name, input spi_frame_t got,
			input spi_frame_t exp);
		if (got !== exp)
			fail_run($sformatf("Error: %s is %h, expected %h", name, got, exp));
	endtask

	function automatic spi_data_t fill_value(input int idx);
		return {idx[6:0], 1'b1, ~idx[6:0], 1'b0};
	endfunction

	function automatic int response_length(input byte_t cmd);
		case (cmd)
		CMD_SPI_READ: return 2;
		CMD_READ_BUF: return 2 * CAPTURE_DEPTH;
		default: return 1;
		endcase
	endfunction

	// expected response byte for everything except buffer reads
	function automatic byte_t expected_byte(input byte_t cmd, input int idx,
			input spi_addr_t addr);
		case (cmd)
		CMD_SPI_WRITE, CMD_ARM: return RESP_ACK;
		CMD_SPI_READ:
			return (idx == 0) ? shadow_regs[addr][15:8] : shadow_regs[addr][7:0];
		default: return RESP_BAD;
		endcase
	endfunction

	function automatic sample_t next_sample(input sample_t prev);
		return prev + 16'd1;
	endfunction

	function automatic spi_frame_t expected_frame(input byte_t cmd, input spi_addr_t addr,
			input spi_data_t data);
		if (cmd == CMD_SPI_READ)
			return {1'b1, addr, 16'h0000};
		return {1'b0, addr, data};
	endfunction

	task automatic step();
		@(posedge lb_clk_i);
		#1;
	endtask

	task automatic send_byte(input byte_t b);
		host_rx_data_i = b;
		host_rx_valid_i = 1'b1;
		while (!host_rx_ready_o)
			step();
		@(posedge lb_clk_i);
		accept_ramp = adc_data_i;
		#1;
		host_rx_valid_i = 1'b0;
	endtask

	task automatic issue_command(input byte_t cmd, input spi_addr_t addr,
			input spi_data_t data);
		int n;
		int frames_before;
		int frames_exp;
		n = response_length(cmd);
		frames_before = frame_total;
		frames_exp = (cmd == CMD_SPI_WRITE || cmd == CMD_SPI_READ) ? 1 : 0;
		cur_cmd = cmd;
		cur_addr = addr;
		cur_data = data;
		resp_start = byte_total;
		if (cmd == CMD_SPI_WRITE)
			shadow_regs[addr] = data;
		send_byte(cmd);
		if (cmd == CMD_ARM)
			arm_ramp = accept_ramp;
		if (frames_exp == 1)
			send_byte({1'b0, addr});
		if (cmd == CMD_SPI_WRITE) begin
			send_byte(data[15:8]);
			send_byte(data[7:0]);
		end
		while (byte_total - resp_start < n)
			step();
		if (!host_rx_ready_o)
			fail_run("decoder did not return to idle after its response");
		if (frame_total - frames_before != frames_exp)
			fail_run("number of SPI frames does not match the command");
	endtask

	// buffer reads are checked by the ramp rule
	task automatic handle_rx_byte(input byte_t b);
		int rel;
		sample_t s;
		rel = byte_total - resp_start;
		if (rel >= response_length(cur_cmd))
			fail_run("more response bytes arrived than the command asks for");
		if (cur_cmd != CMD_READ_BUF) begin
			check_byte("host_tx_data_o", b, expected_byte(cur_cmd, rel, cur_addr));
		end else if (rel % 2 == 0) begin
			hi_byte = b;
		end else begin
			s = {hi_byte, b};
			if ($isunknown(s))
				fail_run("buffer sample has unknown bits");
			if (rel / 2 == 0) begin
				if (s < arm_ramp)
					fail_run("first buffer sample is older than the arm command");
				if (have_prev_cap && s <= last_cap_sample)
					fail_run("second capture did not replace the previous buffer");
			end else begin
				check_sample("host_tx_data_o sample", s, next_sample(prev_sample));
			end
			prev_sample = s;
			if (rel / 2 == CAPTURE_DEPTH - 1) begin
				last_cap_sample = s;
				have_prev_cap = 1'b1;
			end
		end
		byte_total++;
	endtask

	initial begin
		lb_clk_i = 1'b0;
		forever #50 lb_clk_i = ~lb_clk_i;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge lb_clk_i);
		fail_run("watchdog expired before all commands finished");
	end

	// adc ramp with random gaps and host back-pressure in random stretches
	initial begin
		logic [31:0] r;
		int stretch;
		adc_data_i = 16'h1000;
		adc_valid_i = 1'b0;
		host_tx_ready_i = 1'b0;
		stretch = 0;
		@(negedge rst_i);
		forever begin
			step();
			if (adc_valid_i)
				adc_data_i = adc_data_i + 16'd1;
			r = $random(seed);
			adc_valid_i = (r[1:0] != 2'b00);
			if (stretch == 0) begin
				host_tx_ready_i = r[8];
				stretch = int'(r[11:10]);
			end else begin
				stretch--;
			end
		end
	end

	initial begin
		spi_frame_t frame;
		spi_data_t word;
		logic is_read;
		spi_miso_i = 1'b0;
		for (int i = 0; i < 128; i++)
			slave_regs[i] = fill_value(i);
		forever begin
			@(negedge spi_ssb_o);
			frame = '0;
			word = '0;
			is_read = 1'b0;
			for (int i = 0; i < 24; i++) begin
				@(posedge spi_sclk_o);
				frame = {frame[22:0], spi_mosi_o};
				@(negedge spi_sclk_o);
				#1;
				// address complete after eight bits
				if (i == 7) begin
					is_read = frame[7];
					word = slave_regs[frame[6:0]];
				end
				if (is_read && i >= 7 && i < 23)
					spi_miso_i = word[22 - i];
				else
					spi_miso_i = 1'b0;
			end
			@(posedge spi_ssb_o);
			check_spi_frame("spi_mosi_o frame", frame,
				expected_frame(cur_cmd, cur_addr, cur_data));
			if (!frame[23])
				slave_regs[frame[22:16]] = frame[15:0];
			frame_total++;
		end
	end

	always @(posedge lb_clk_i) begin
		if (host_tx_valid_o && host_tx_ready_i)
			handle_rx_byte(host_tx_data_o);
	end

	initial begin
		logic [31:0] r;
		spi_addr_t wr_addr [6];
		spi_data_t wr_data [6];
		host_rx_data_i = '0;
		host_rx_valid_i = 1'b0;
		rst_i = 1'b1;
		for (int i = 0; i < 128; i++)
			shadow_regs[i] = fill_value(i);
		// few addresses so some get written twice
		for (int i = 0; i < 6; i++) begin
			r = $random(seed);
			wr_addr[i] = {5'b10100, r[1:0]};
			wr_data[i] = r[31:16];
		end
		repeat (3) @(posedge lb_clk_i);
		#1;
		rst_i = 1'b0;
		if (host_rx_ready_o !== 1'b1 || host_tx_valid_o !== 1'b0 ||
				spi_ssb_o !== 1'b1 || spi_sclk_o !== 1'b0)
			fail_run("outputs are not idle after reset");
		for (int i = 0; i < 6; i++)
			issue_command(CMD_SPI_WRITE, wr_addr[i], wr_data[i]);
		for (int i = 0; i < 6; i++)
			issue_command(CMD_SPI_READ, wr_addr[i], '0);
		repeat (2) begin
			issue_command(CMD_ARM, '0, '0);
			issue_command(CMD_READ_BUF, '0, '0);
		end
		issue_command(8'h7f, '0, '0);
		issue_command(CMD_SPI_READ, wr_addr[0], '0);
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

//--- oscope.f
hdl/oscope_pkg.sv
hdl/spi_chain_master.sv
hdl/sample_capture.sv
hdl/host_cmd_decoder.sv
hdl/oscope_top.sv
testbench/oscope_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -Wno-fatal
TOP ?= oscope_tb
FILELIST ?= oscope.f
OBJ_DIR ?= obj_dir
PASS_MSG = PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
